// ==== rtl/lf_envelope_pkg.sv ====
package lf_envelope_pkg;

    // widths and window defaults of the envelope data path

    // a beam sample is the sum of five codes that each lie between -16 and 15
    // once the half offset is taken out, so the sum spans -80 to 75
    // -80 does not fit in seven bits, so one more bit is carried
    localparam int sample_bits = 8;

    // samples per beam that arrive together on every clock
    localparam int nsamp = 4;

    // the corrected square (s+2)(s+3) peaks at 6006 at both ends of the range
    localparam int square_bits = 14;

    // four squares of one clock added together peak at 24024
    localparam int group_bits = 16;

    // the window sum stays below 2**19 for windows of up to 16 clocks
    // 16 groups at 24024 give 384384
    localparam int sum_bits = 19;

    // envelope width after the right shift
    // a full window of extremes gives 36036 with the default shift
    localparam int env_bits = 17;

    // window length in clocks
    // 12 clocks of 4 samples cover the 48 squares of the envelope
    localparam int default_window = 12;

    // right shift applied to the window sum on its way out
    localparam int default_shift = 3;

endpackage

// ==== rtl/lf_trigger_pkg.sv ====
package lf_trigger_pkg;

    // widths and defaults of the threshold trigger

    // the threshold is compared directly against an envelope
    // so it has the same width
    localparam int thresh_bits = lf_envelope_pkg::env_bits;

    // clocks that a beam stays blocked after its trigger fires
    localparam int default_holdoff = 16;

    // hold-off counter width
    // five bits cover the default and any hold-off up to 31
    localparam int holdoff_bits = 5;

endpackage

// ==== rtl/beam_square.sv ====
module beam_square (
    input  logic clk_i,
    input  logic reset_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::sample_bits-1:0] samples_a_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::sample_bits-1:0] samples_b_i,
    output logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::square_bits-1:0] square_a_o,
    output logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::square_bits-1:0] square_b_o
);

    import lf_envelope_pkg::*;

    // each sample element is a two's complement value
    // the packed array itself carries no sign, so every element is cast on use

    // inside this block beam 0 is A and beam 1 is B
    logic [1:0][nsamp-1:0][sample_bits-1:0] samples;
    logic [1:0][nsamp-1:0][square_bits-1:0] square_d;
    logic [1:0][nsamp-1:0][square_bits-1:0] square_q;

    // the true sample is s+0.5, so its square is s*s + s + 0.25
    // the codes themselves are half offset and the sum of five carries +2.5
    // which gives (s+2.5)**2 = s*s + 5s + 6.25
    // dropping the constant 0.25 leaves s*s + 5s + 6 = (s+2)(s+3)
    // the product of two neighbouring integers is never negative
    // and -80 and 75 both land on 6006, so the two extremes weigh the same
    function automatic logic [square_bits-1:0] corrected_square(
        input logic [sample_bits-1:0] s
    );
        logic signed [sample_bits+1:0]   lo;
        logic signed [sample_bits+1:0]   hi;
        logic signed [2*sample_bits+3:0] prod;
        lo = $signed(s) + 2;
        hi = $signed(s) + 3;
        prod = lo * hi;
        // the product is at most 6006 over the sample range, so the low bits hold it
        return prod[square_bits-1:0];
    endfunction

    assign samples[0] = samples_a_i;
    assign samples[1] = samples_b_i;

    // all eight squares are formed side by side in the same clock
    for (genvar b = 0; b < 2; b++) begin : g_beam
        for (genvar k = 0; k < nsamp; k++) begin : g_samp
            assign square_d[b][k] = corrected_square(samples[b][k]);
        end
    end

    // one register stage between the samples and the squares
    // a cleared register enters the sum as an empty group after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            square_q <= '0;
        end else begin
            square_q <= square_d;
        end
    end

    assign square_a_o = square_q[0];
    assign square_b_o = square_q[1];

endmodule

// ==== rtl/dual_envelope_sum.sv ====
module dual_envelope_sum #(
    parameter int window_len = lf_envelope_pkg::default_window,
    parameter int out_shift  = lf_envelope_pkg::default_shift
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::square_bits-1:0] square_a_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::square_bits-1:0] square_b_i,
    output logic [lf_envelope_pkg::env_bits-1:0] env_a_o,
    output logic [lf_envelope_pkg::env_bits-1:0] env_b_o
);

    import lf_envelope_pkg::*;

    // running sum over the last window_len groups of four squares
    //
    // with x the group sum of one clock, the accumulator follows
    // y = y z^-1 + x - x z^-window_len
    // which is the same as x + x z^-1 + ... + x z^-(window_len-1)
    //
    // stage 1 forms x and subtracts the group that leaves the window
    // stage 2 adds that difference into the accumulator
    //
    // sum_bits holds windows of up to 16 clocks

    // beam 0 is A and beam 1 is B
    logic [1:0][nsamp-1:0][square_bits-1:0]      square;
    logic [1:0][group_bits-1:0]                  group_sum;
    logic [1:0][window_len-1:0][group_bits-1:0]  delay_q;
    logic [1:0][group_bits:0]                    diff_d;
    logic [1:0][group_bits:0]                    diff_q;
    logic [1:0][sum_bits-1:0]                    acc_q;
    logic [1:0][sum_bits-1:0]                    acc_shifted;

    assign square[0] = square_a_i;
    assign square[1] = square_b_i;

    // group sum and the difference against the oldest stored group
    // delay_q[b][window_len-1] holds the group from window_len clocks back
    // the difference is one bit wider and two's complement, since an old
    // group may be larger than the new one
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            group_sum[b] = '0;
            for (int k = 0; k < nsamp; k++) begin
                group_sum[b] = group_sum[b] + group_bits'(square[b][k]);
            end
            diff_d[b] = {1'b0, group_sum[b]} - {1'b0, delay_q[b][window_len-1]};
        end
    end

    // stage 1 registers
    // the delay line shifts once per clock, newest group at index 0
    // clearing it makes every group older than reset count as zero
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            delay_q <= '0;
            diff_q  <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                delay_q[b][0] <= group_sum[b];
                for (int j = 1; j < window_len; j++) begin
                    delay_q[b][j] <= delay_q[b][j-1];
                end
                diff_q[b] <= diff_d[b];
            end
        end
    end

    // stage 2, the accumulator
    // the difference is sign extended and the add wraps modulo 2**sum_bits
    // the true window sum never goes negative or past the width,
    // so the wrapped result is always the exact sum
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            acc_q <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                acc_q[b] <= acc_q[b]
                            + {{(sum_bits-group_bits-1){diff_q[b][group_bits]}}, diff_q[b]};
            end
        end
    end

    // scale the window sum down on the way out
    // with a small shift the top bits are dropped, so out_shift must
    // bring the sum within env_bits for the chosen window
    for (genvar b = 0; b < 2; b++) begin : g_shift
        assign acc_shifted[b] = acc_q[b] >> out_shift;
    end

    assign env_a_o = acc_shifted[0][env_bits-1:0];
    assign env_b_o = acc_shifted[1][env_bits-1:0];

endmodule

// ==== rtl/envelope_trigger.sv ====
module envelope_trigger #(
    parameter int holdoff = lf_trigger_pkg::default_holdoff
) (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic [lf_envelope_pkg::env_bits-1:0] env_a_i,
    input  logic [lf_envelope_pkg::env_bits-1:0] env_b_i,
    input  logic [lf_trigger_pkg::thresh_bits-1:0] thresh_i,
    output logic [1:0]                           trig_o
);

    import lf_trigger_pkg::*;

    // rising threshold crossing per beam, bit 0 is beam A and bit 1 is beam B
    // a pulse on trig_o lasts one clock and blocks that beam for holdoff clocks

    // envelope above the threshold in this clock
    logic [1:0] above;
    // the same for the envelope of the previous clock
    logic [1:0] above_q;
    // crossing seen and the beam is not blocked
    logic [1:0] fire;
    // clocks left before the beam may fire again
    logic [1:0][holdoff_bits-1:0] count_q;

    // strictly above, an envelope equal to the threshold does not count
    assign above[0] = env_a_i > thresh_i;
    assign above[1] = env_b_i > thresh_i;

    for (genvar b = 0; b < 2; b++) begin : g_fire
        // a rising edge of above that arrives while the counter is still
        // running is lost, it does not wait for the hold-off to end
        assign fire[b] = above[b] & ~above_q[b] & (count_q[b] == '0);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            above_q <= '0;
            count_q <= '0;
            trig_o  <= '0;
        end else begin
            above_q <= above;
            trig_o  <= fire;
            for (int b = 0; b < 2; b++) begin
                if (fire[b]) begin
                    // the counter is loaded in the clock the pulse is registered
                    count_q[b] <= holdoff_bits'(holdoff);
                end else if (count_q[b] != '0) begin
                    count_q[b] <= count_q[b] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/lf_envelope_top.sv ====
module lf_envelope_top #(
    parameter int window_len = lf_envelope_pkg::default_window,
    parameter int out_shift  = lf_envelope_pkg::default_shift,
    parameter int holdoff    = lf_trigger_pkg::default_holdoff
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::sample_bits-1:0] samples_a_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::sample_bits-1:0] samples_b_i,
    input  logic [lf_trigger_pkg::thresh_bits-1:0] thresh_i,
    output logic [lf_envelope_pkg::env_bits-1:0] env_a_o,
    output logic [lf_envelope_pkg::env_bits-1:0] env_b_o,
    output logic [1:0] trig_o
);

    import lf_envelope_pkg::*;

    // dual-beam envelope detector
    // a group sampled at one edge shows up on env_a_o and env_b_o three edges
    // later (square, group difference, accumulator) and on trig_o one edge after that

    // registered corrected squares of both beams
    logic [nsamp-1:0][square_bits-1:0] square_a;
    logic [nsamp-1:0][square_bits-1:0] square_b;

    beam_square u_square (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .samples_a_i (samples_a_i),
        .samples_b_i (samples_b_i),
        .square_a_o  (square_a),
        .square_b_o  (square_b)
    );

    dual_envelope_sum #(
        .window_len (window_len),
        .out_shift  (out_shift)
    ) u_sum (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .square_a_i (square_a),
        .square_b_i (square_b),
        .env_a_o    (env_a_o),
        .env_b_o    (env_b_o)
    );

    // the trigger watches the same envelopes that leave the top
    envelope_trigger #(
        .holdoff (holdoff)
    ) u_trig (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .env_a_i  (env_a_o),
        .env_b_i  (env_b_o),
        .thresh_i (thresh_i),
        .trig_o   (trig_o)
    );

endmodule

// ==== bench/lf_envelope_assert.sv ====
module lf_envelope_assert #(
    parameter int holdoff = lf_trigger_pkg::default_holdoff
) (
    input logic                                 clk_i,
    input logic                                 reset_i,
    input logic [lf_envelope_pkg::env_bits-1:0] env_a_i,
    input logic [lf_envelope_pkg::env_bits-1:0] env_b_i,
    input logic [1:0]                           trig_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // number of failed assertions, read by the testbench at the end of the run
    int fail_count = 0;

    // a trigger is a single clock wide
    trig_a_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        trig_i[0] |=> !trig_i[0])
        else begin
            fail_count++;
            $error("trig_o[0] stayed high for more than one clock");
        end

    trig_b_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        trig_i[1] |=> !trig_i[1])
        else begin
            fail_count++;
            $error("trig_o[1] stayed high for more than one clock");
        end

    // after a pulse the beam stays quiet for the whole hold-off
    trig_a_holdoff: assert property (@(posedge clk_i) disable iff (reset_i)
        trig_i[0] |=> !trig_i[0] [*holdoff])
        else begin
            fail_count++;
            $error("trig_o[0] fired again inside its hold-off");
        end

    trig_b_holdoff: assert property (@(posedge clk_i) disable iff (reset_i)
        trig_i[1] |=> !trig_i[1] [*holdoff])
        else begin
            fail_count++;
            $error("trig_o[1] fired again inside its hold-off");
        end

    // a reset clock leaves both envelopes and the triggers cleared
    reset_clears: assert property (@(posedge clk_i)
        reset_i |=> (env_a_i == '0 && env_b_i == '0 && trig_i == '0))
        else begin
            fail_count++;
            $error("envelopes or triggers not cleared by reset");
        end

endmodule

bind lf_envelope_top lf_envelope_assert #(
    .holdoff (holdoff)
) u_assert (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .env_a_i (env_a_o),
    .env_b_i (env_b_o),
    .trig_i  (trig_o)
);

// ==== bench/lf_envelope_checker.sv ====
module lf_envelope_checker #(
    parameter int window_len = lf_envelope_pkg::default_window,
    parameter int out_shift  = lf_envelope_pkg::default_shift,
    parameter int holdoff    = lf_trigger_pkg::default_holdoff
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::sample_bits-1:0] samples_a_i,
    input  logic [lf_envelope_pkg::nsamp-1:0][lf_envelope_pkg::sample_bits-1:0] samples_b_i,
    input  logic [lf_trigger_pkg::thresh_bits-1:0] thresh_i,
    input  logic [lf_envelope_pkg::env_bits-1:0] env_a_i,
    input  logic [lf_envelope_pkg::env_bits-1:0] env_b_i,
    input  logic [1:0] trig_i,
    input  int   test_id_i,
    input  logic test_end_i,
    input  int   exp_trig_a_i,
    input  int   exp_trig_b_i,
    output int   pass_count_o,
    output int   fail_count_o,
    output int   error_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import lf_envelope_pkg::*;

    localparam int hist_depth = 32;

    // group square sums per beam, index 0 is the group taken at the last edge
    int hist [2][hist_depth];
    // envelope the DUT should show at the current edge
    int env_exp [2];
    // trigger pulses seen in the running test
    int trig_seen [2];
    // hold-off counters and above-threshold state of the model
    int count_m [2];
    logic [1:0] above_m;
    // trigger the DUT should show at the next edge
    logic [1:0] trig_exp;
    // set once the first reset clock has cleared the DUT
    logic started;
    int test_errors;

    initial begin
        pass_count_o  = 0;
        fail_count_o  = 0;
        error_count_o = 0;
        test_errors   = 0;
        started       = 1'b0;
        above_m       = '0;
        trig_exp      = '0;
    end

    // (s+2.5)**2 without the constant 0.25, that is s*s + 5s + 6
    function automatic int square_of(input logic [sample_bits-1:0] s);
        int v;
        v = int'($signed(s));
        return v * v + 5 * v + 6;
    endfunction

    function automatic int group_of(input logic [nsamp-1:0][sample_bits-1:0] g);
        int sum;
        sum = 0;
        for (int k = 0; k < nsamp; k++) begin
            sum += square_of(g[k]);
        end
        return sum;
    endfunction

    task automatic compare(input string name, input int want, input logic [31:0] got);
        if (got !== want) begin
            $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, want, got);
            test_errors++;
            error_count_o++;
        end
    endtask

    // one line per test, pulse counts checked against the stim file
    task automatic report_test();
        compare("trig_o[0] pulse count", exp_trig_a_i, 32'(trig_seen[0]));
        compare("trig_o[1] pulse count", exp_trig_b_i, 32'(trig_seen[1]));
        if (test_errors == 0) begin
            pass_count_o++;
            $display("test %0d passed with %0d and %0d trigger pulses",
                     test_id_i, trig_seen[0], trig_seen[1]);
        end else begin
            fail_count_o++;
            $display("test %0d: %0d errors", test_id_i, test_errors);
        end
        test_errors  = 0;
        trig_seen[0] = 0;
        trig_seen[1] = 0;
    endtask

    // every value is read as it stands just before the edge
    always @(posedge clk_i) begin : model
        logic fire;
        // the envelope before this edge holds the groups of edges m-3 down to m-2-window
        for (int b = 0; b < 2; b++) begin
            env_exp[b] = 0;
            for (int i = 2; i < window_len + 2; i++) begin
                env_exp[b] += hist[b][i];
            end
            env_exp[b] = env_exp[b] >>> out_shift;
        end
        if (started) begin
            compare("env_a_o", env_exp[0], 32'(env_a_i));
            compare("env_b_o", env_exp[1], 32'(env_b_i));
            compare("trig_o[0]", int'(trig_exp[0]), 32'(trig_i[0]));
            compare("trig_o[1]", int'(trig_exp[1]), 32'(trig_i[1]));
        end
        if (reset_i) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < hist_depth; i++) begin
                    hist[b][i] = 0;
                end
                count_m[b] = 0;
            end
            above_m  = '0;
            trig_exp = '0;
            started  = 1'b1;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (trig_i[b] === 1'b1) begin
                    trig_seen[b]++;
                end
                // a rising crossing fires unless the beam is still held off
                fire = env_exp[b] > int'(thresh_i) && !above_m[b] && count_m[b] == 0;
                trig_exp[b] = fire;
                if (fire) begin
                    count_m[b] = holdoff;
                end else if (count_m[b] > 0) begin
                    count_m[b]--;
                end
                above_m[b] = env_exp[b] > int'(thresh_i);
                for (int i = hist_depth - 1; i > 0; i--) begin
                    hist[b][i] = hist[b][i-1];
                end
            end
            hist[0][0] = group_of(samples_a_i);
            hist[1][0] = group_of(samples_b_i);
            if (test_end_i) begin
                report_test();
            end
        end
    end

endmodule

// ==== bench/lf_envelope_tb.sv ====
module lf_envelope_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import lf_envelope_pkg::*;
    import lf_trigger_pkg::*;

    localparam int window_len   = default_window;
    localparam int out_shift    = default_shift;
    localparam int holdoff      = default_holdoff;
    localparam int reset_cycles = 5;
    localparam int flush_groups = 16;
    localparam int margin       = 50;
    localparam int stim_depth   = 512;
    localparam int sample_min   = -80;
    localparam int sample_max   = 75;

    // -2 is the code whose corrected square is zero, so it is the quiet input
    localparam logic [nsamp-1:0][sample_bits-1:0] quiet_group = {nsamp{sample_bits'(-2)}};

    logic clk_i;
    logic reset_i;
    logic [nsamp-1:0][sample_bits-1:0] samples_a;
    logic [nsamp-1:0][sample_bits-1:0] samples_b;
    logic [thresh_bits-1:0] thresh;
    logic [env_bits-1:0] env_a;
    logic [env_bits-1:0] env_b;
    logic [1:0] trig;

    // test bookkeeping shared with the checker
    int   test_id;
    logic test_end;
    int   exp_trig_a;
    int   exp_trig_b;
    int   pass_count;
    int   fail_count;
    int   error_count;

    logic [31:0] stim_mem [stim_depth];
    logic [15:0] lfsr_q = 16'd94;
    int cycle_count = 0;
    int cycle_limit = margin;

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    lf_envelope_top #(
        .window_len (window_len),
        .out_shift  (out_shift),
        .holdoff    (holdoff)
    ) u_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .samples_a_i (samples_a),
        .samples_b_i (samples_b),
        .thresh_i    (thresh),
        .env_a_o     (env_a),
        .env_b_o     (env_b),
        .trig_o      (trig)
    );

    lf_envelope_checker #(
        .window_len (window_len),
        .out_shift  (out_shift),
        .holdoff    (holdoff)
    ) u_checker (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .samples_a_i   (samples_a),
        .samples_b_i   (samples_b),
        .thresh_i      (thresh),
        .env_a_i       (env_a),
        .env_b_i       (env_b),
        .trig_i        (trig),
        .test_id_i     (test_id),
        .test_end_i    (test_end),
        .exp_trig_a_i  (exp_trig_a),
        .exp_trig_b_i  (exp_trig_b),
        .pass_count_o  (pass_count),
        .fail_count_o  (fail_count),
        .error_count_o (error_count)
    );

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_group(output logic [nsamp-1:0][sample_bits-1:0] g);
        int v;
        for (int k = 0; k < nsamp; k++) begin
            v = 0;
            for (int i = 0; i < sample_bits; i++) begin
                lfsr_q = lfsr_next(lfsr_q);
                v = (v << 1) | int'(lfsr_q[0]);
            end
            // the bits read as a signed byte, clamped into the sample range
            if (v >= (1 << (sample_bits - 1))) begin
                v = v - (1 << sample_bits);
            end
            if (v < sample_min) begin
                v = sample_min;
            end else if (v > sample_max) begin
                v = sample_max;
            end
            g[k] = sample_bits'(v);
        end
    endtask

    // inputs change 1 ns after the edge and hold until the next one
    task automatic drive_group(input logic [nsamp-1:0][sample_bits-1:0] a,
                               input logic [nsamp-1:0][sample_bits-1:0] b,
                               input logic last);
        samples_a = a;
        samples_b = b;
        test_end  = last;
        @(posedge clk_i);
        #1;
    endtask

    // the limit follows from the group counts in the stim file
    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin : run
        int p;
        int count;
        int mode;
        int total_groups;
        int total_tests;
        int tests_run;
        logic [nsamp-1:0][sample_bits-1:0] word_a;
        logic [nsamp-1:0][sample_bits-1:0] word_b;
        reset_i    = 1'b1;
        samples_a  = quiet_group;
        samples_b  = quiet_group;
        thresh     = '0;
        test_id    = 0;
        test_end   = 1'b0;
        exp_trig_a = 0;
        exp_trig_b = 0;
        $readmemh("bench/lf_envelope_stim.txt", stim_mem);

        // a first pass over the records sizes the timeout
        p = 0;
        total_groups = 0;
        total_tests  = 0;
        while (p < stim_depth - 6 && !$isunknown(stim_mem[p]) && stim_mem[p] != 0) begin
            total_groups += stim_mem[p+2];
            total_tests++;
            p += (stim_mem[p+3] == 0) ? 6 + 2 * stim_mem[p+2] : 6;
        end
        cycle_limit = total_groups + flush_groups * total_tests + margin;

        repeat (reset_cycles) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        p = 0;
        tests_run = 0;
        while (p < stim_depth - 6 && !$isunknown(stim_mem[p]) && stim_mem[p] != 0) begin
            test_id    = stim_mem[p];
            thresh     = stim_mem[p+1][thresh_bits-1:0];
            count      = stim_mem[p+2];
            mode       = stim_mem[p+3];
            exp_trig_a = stim_mem[p+4];
            exp_trig_b = stim_mem[p+5];
            p += 6;
            for (int g = 0; g < count; g++) begin
                if (mode == 0) begin
                    word_a = stim_mem[p];
                    word_b = stim_mem[p+1];
                    p += 2;
                end else begin
                    random_group(word_a);
                    random_group(word_b);
                end
                drive_group(word_a, word_b, 1'b0);
            end
            // quiet groups empty the window, the last one closes the test
            for (int f = 0; f < flush_groups; f++) begin
                drive_group(quiet_group, quiet_group, f == flush_groups - 1);
            end
            tests_run++;
        end
        test_end = 1'b0;
        @(posedge clk_i);
        #1;

        $display("summary: %0d tests passed, %0d failed, %0d errors, %0d assertion failures",
                 pass_count, fail_count, error_count, u_dut.u_assert.fail_count);
        if (tests_run > 0 && pass_count == tests_run && fail_count == 0 && error_count == 0
            && u_dut.u_assert.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== lf_envelope.f ====
rtl/lf_envelope_pkg.sv
rtl/lf_trigger_pkg.sv
rtl/beam_square.sv
rtl/dual_envelope_sum.sv
rtl/envelope_trigger.sv
rtl/lf_envelope_top.sv
bench/lf_envelope_assert.sv
bench/lf_envelope_checker.sv
bench/lf_envelope_tb.sv

// ==== bench/lf_envelope_stim.txt ====
// record: test id, threshold, group count, mode (0 groups listed here, 1 LFSR groups),
// expected trig_o pulses of beam A and of beam B, then one beam A and one beam B word per group
// each word packs four 8-bit samples, FE (-2) squares to zero, B0 is -80 and 4B is 75
// single extreme group, -80 on beam A against 75 on beam B
1 3E8 1 0 1 1
B0B0B0B0 4B4B4B4B
// data on beam A only
2 1388 2 0 1 0
4B4B4B4B FEFEFEFE B0B0B0B0 FEFEFEFE
// data on beam B only
3 7D0 2 0 0 1
FEFEFEFE 4B4BFEFE FEFEFEFE B0B0B0B0
// long LFSR run, threshold above any envelope
4 1FFFF 28 1 0 0
// window filled with extremes on both beams, saturates at 36036
5 88B8 D 0 1 1
B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0
B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0
B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0 B0B04B4B 4B4BB0B0
B0B04B4B 4B4BB0B0
// three crossings on beam A, the second falls inside the hold-off
6 7D0 1B 0 2 0
B0B0B0B0 FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE
FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE
FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE
FEFEFEFE FEFEFEFE 4B4B4B4B FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE
FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE
FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE
FEFEFEFE FEFEFEFE FEFEFEFE FEFEFEFE B0B04B4B FEFEFEFE
0
